// ==== Makefile ====
# Verilator build of the microcode sequencer testbench.
# Any variable below can be overridden on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= seq_tb
FILELIST  ?= cadr_seq.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== cadr_seq.f ====
+incdir+verification
hw/seq_ucode_pkg.sv
hw/seq_mach_pkg.sv
hw/spc_if.sv
hw/seq_decode.sv
hw/seq_contrl.sv
hw/seq_phase.sv
hw/spc_stack.sv
hw/pc_select.sv
hw/seq_top.sv
verification/seq_tb.sv

// ==== hw/pc_select.sv ====
// Microprogram counter
`timescale 1ns/10ps

module pc_select
(
   input  logic                  clk,
   input  logic                  reset,
   input  seq_mach_pkg::pc_sel_t pc_sel,
   input  seq_mach_pkg::pc_t     jaddr,
   input  seq_mach_pkg::pc_t     dpc,
   input  logic                  state_fetch,
   output seq_mach_pkg::pc_t     pc,
   spc_if.sel                    spc
);
   import seq_mach_pkg::*;

   pc_t ipc;
   pc_t npc;

   assign ipc          = pc + 1'b1;
   assign spc.ret_addr = ipc;   // a call returns to the following word.

   always_comb
   begin
      case (pc_sel)
         SEL_SPC: npc = spc.top;
         SEL_IR:  npc = jaddr;
         SEL_DPC: npc = dpc;
         SEL_IPC: npc = ipc;
         default: npc = ipc;
      endcase
   end

   // the new address is taken once per instruction, at the end of fetch.
   always_ff @(posedge clk)
   begin
      if (reset)
         pc <= '0;
      else if (state_fetch)
         pc <= npc;
   end

endmodule

// ==== hw/seq_contrl.sv ====
// PC and SPC control
`timescale 1ns/10ps

module seq_contrl
(
   input  logic                   clk,
   input  logic                   reset,
   input  seq_ucode_pkg::uinst_t  ir,
   input  logic                   irjump,
   input  logic                   irdisp,
   input  logic [3:0]             funct,
   input  logic                   srcspc,
   input  logic                   srcspcpop,
   input  logic                   destspc,
   input  logic                   jcond,
   input  logic                   trap,
   input  logic                   dn,
   input  logic                   dp,
   input  logic                   dr,
   input  logic                   state_alu,
   input  logic                   state_write,
   input  logic                   state_fetch,
   input  logic                   nop11,
   output seq_mach_pkg::pc_sel_t  pc_sel,
   output logic                   spcdrive,
   output logic                   popj,
   output logic                   n,
   output logic                   nop,
   spc_if.ctl                     spc
);
   import seq_ucode_pkg::*;

   logic inv, call, ret;
   logic jmp, dsp, dst;
   logic dfall, dispenb, ignpopj;
   logic jfalse, jcalf, jret, jretf, iwrite;
   logic jtrue, jtaken;
   logic ipopj, srcspcpopreal;
   logic spush, spop;
   logic pcs1, pcs0;
   logic iwrited;
   logic inop;

   assign inv  = ir[INV_BIT];
   assign call = ir[CALL_BIT];
   assign ret  = ir[RET_BIT];

   // a cancelled word still fetches in sequence but has no side effects.
   assign jmp = irjump & ~nop;
   assign dsp = irdisp & ~nop;
   assign dst = destspc & ~nop;

   assign dfall   = dr & dp;               // dispatch push and return together.
   assign dispenb = dsp & ~funct[2];
   assign ignpopj = dsp & ~dr;             // dispatch without return overrides popj.

   assign jfalse = jmp & inv;              // jump on inverted sense.
   assign jtrue  = jmp & ~inv;
   assign jcalf  = jfalse & call;
   assign jret   = jmp & ~call & ret;
   assign jretf  = jret & inv;
   assign iwrite = jmp & call & ret;       // microcode write.

   // the jump is taken when the condition matches the sense bit.
   assign jtaken = (jfalse & ~jcond) | (jtrue & jcond);

   assign ipopj         = ir[POPJ_BIT] & ~nop;
   assign popj          = ipopj | iwrited;   // a write delays its popj by one word.
   assign srcspcpopreal = srcspcpop & ~nop;

   assign spop = ((srcspcpopreal | popj) & ~ignpopj) |
                 (dispenb & dr & ~dp) |
                 (jret & ~inv & jcond) |
                 (jretf & ~jcond);

   assign spush = dst |
                  (jcalf & ~jcond) |
                  (dispenb & dp & ~dr) |
                  (jtrue & call & jcond);

   assign spc.push      = spush;
   assign spc.pop       = spop;
   assign spc.wr_strobe = (spush | spop) & state_write;
   // the top latch follows the stack until write ends, then holds through fetch.
   assign spc.rd_strobe = ~state_fetch;

   assign spcdrive = (srcspc | srcspcpop) & (state_alu | state_write | state_fetch);

   // select codes: 0 spc, 1 jump field, 2 dpc, 3 ipc.
   assign pcs1 = ~((popj & ~ignpopj) | jtaken | (dispenb & dr & ~dp));

   assign pcs0 = ~(popj |
                   (dispenb & ~dfall) |
                   (jretf & ~jcond) |
                   (jret & ~inv & jcond));

   assign pc_sel = {pcs1, pcs0};

   // N cancels the word that follows this one.
   assign n = trap |
              iwrited |
              (dispenb & dn) |
              (jtaken & ir[NEXT_BIT]);

   assign nop = trap | inop | nop11;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         inop    <= 1'b0;
         iwrited <= 1'b0;
      end
      else if (state_fetch)
      begin
         inop    <= n;
         iwrited <= iwrite;
      end
   end

endmodule

// ==== hw/seq_decode.sv ====
// Sequencing field decoder
`timescale 1ns/10ps

module seq_decode
(
   input  seq_ucode_pkg::uinst_t ir,
   output logic                  irjump,
   output logic                  irdisp,
   output logic [3:0]            funct,
   output logic                  srcspc,
   output logic                  srcspcpop,
   output logic                  destspc,
   spc_if.dec                    spc
);
   import seq_ucode_pkg::*;

   op_t   op;
   src_t  src;
   dest_t dest;
   logic  has_dest;

   assign op   = ir[OP_LSB +: OP_W];
   assign src  = ir[SRC_LSB +: SRC_W];
   assign dest = ir[DEST_LSB +: DEST_W];

   assign irjump = (op == OP_JUMP);
   assign irdisp = (op == OP_DISPATCH);
   assign funct  = ir[FUNCT_LSB +: FUNCT_W];

   // only alu and byte words carry a destination field; in jump words
   // the same bits hold part of the jump address.
   assign has_dest = (op == OP_ALU) || (op == OP_BYTE);

   assign srcspc    = (src == SRC_SPC);
   assign srcspcpop = (src == SRC_SPC_POP);
   assign destspc   = has_dest && (dest == DEST_SPC);

   assign spc.load_m = destspc;   // the stack destination pushes M data.

endmodule

// ==== hw/seq_mach_pkg.sv ====
// Sequencer machine types
package seq_mach_pkg;

   // microprogram address, wide enough for the 16K-word control memory.
   typedef logic [13:0] pc_t;

   // next-address select, as formed by the control block.
   typedef logic [1:0] pc_sel_t;

   localparam pc_sel_t SEL_SPC = 2'd0;   // return through the stack top.
   localparam pc_sel_t SEL_IR  = 2'd1;   // jump field of the word.
   localparam pc_sel_t SEL_DPC = 2'd2;   // dispatch address.
   localparam pc_sel_t SEL_IPC = 2'd3;   // incremented pc.

   // the four phases of one microinstruction cycle.
   typedef enum logic [1:0]
   {
      PH_DECODE = 2'd0,
      PH_ALU    = 2'd1,
      PH_WRITE  = 2'd2,
      PH_FETCH  = 2'd3
   } seq_phase_t;

endpackage

// ==== hw/seq_phase.sv ====
// Four-phase cycle sequencer
`timescale 1ns/10ps

module seq_phase
(
   input  logic                     clk,
   input  logic                     reset,
   output seq_mach_pkg::seq_phase_t phase,
   output logic                     state_alu,
   output logic                     state_write,
   output logic                     state_fetch
);
   import seq_mach_pkg::*;

   seq_phase_t phase_next;

   always_comb
   begin
      case (phase)
         PH_DECODE: phase_next = PH_ALU;
         PH_ALU:    phase_next = PH_WRITE;
         PH_WRITE:  phase_next = PH_FETCH;
         default:   phase_next = PH_DECODE;   // fetch wraps back to decode.
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         phase <= PH_DECODE;
      else
         phase <= phase_next;
   end

   assign state_alu   = (phase == PH_ALU);
   assign state_write = (phase == PH_WRITE);
   assign state_fetch = (phase == PH_FETCH);

endmodule

// ==== hw/seq_top.sv ====
// Microcode sequencer top
`timescale 1ns/10ps

module seq_top
#(
   parameter int SPC_DEPTH_LOG2 = 5
)
(
   input  logic                      clk,
   input  logic                      reset,
   input  seq_ucode_pkg::uinst_t     ir,
   input  logic                      jcond,
   input  logic                      trap,
   input  logic                      dn,
   input  logic                      dp,
   input  logic                      dr,
   input  seq_mach_pkg::pc_t         dpc,
   input  seq_mach_pkg::pc_t         m_data,
   output seq_mach_pkg::pc_t         pc,
   output seq_mach_pkg::seq_phase_t  phase,
   output logic                      nop,
   output seq_mach_pkg::pc_t         spc_out,
   output logic                      spc_drive,
   output logic [SPC_DEPTH_LOG2-1:0] spc_ptr
);
   import seq_ucode_pkg::*;
   import seq_mach_pkg::*;

   logic       state_alu, state_write, state_fetch;
   logic       irjump, irdisp;
   logic [3:0] funct;
   logic       srcspc, srcspcpop, destspc;
   pc_sel_t    pc_sel;
   pc_t        jaddr;

   spc_if spc ();

   assign spc.m_data = m_data;
   assign spc_out    = spc.top;
   assign jaddr      = ir[JADDR_LSB +: JADDR_W];

   seq_phase u_phase (.clk(clk), .reset(reset), .phase(phase), .state_alu(state_alu),
                      .state_write(state_write), .state_fetch(state_fetch));

   seq_decode u_decode (.ir(ir), .irjump(irjump), .irdisp(irdisp), .funct(funct),
                        .srcspc(srcspc), .srcspcpop(srcspcpop), .destspc(destspc),
                        .spc(spc.dec));

   // no second nop source in this design.
   seq_contrl u_contrl (.clk(clk), .reset(reset), .ir(ir), .irjump(irjump),
                        .irdisp(irdisp), .funct(funct), .srcspc(srcspc),
                        .srcspcpop(srcspcpop), .destspc(destspc), .jcond(jcond),
                        .trap(trap), .dn(dn), .dp(dp), .dr(dr), .state_alu(state_alu),
                        .state_write(state_write), .state_fetch(state_fetch),
                        .nop11(1'b0), .pc_sel(pc_sel), .spcdrive(spc_drive),
                        .popj(), .n(), .nop(nop), .spc(spc.ctl));

   spc_stack #(.SPC_DEPTH_LOG2(SPC_DEPTH_LOG2)) u_stack (.clk(clk), .reset(reset),
                                                         .spc(spc.stk), .ptr(spc_ptr));

   pc_select u_pc (.clk(clk), .reset(reset), .pc_sel(pc_sel), .jaddr(jaddr), .dpc(dpc),
                   .state_fetch(state_fetch), .pc(pc), .spc(spc.sel));

endmodule

// ==== hw/seq_ucode_pkg.sv ====
// Microinstruction word format
package seq_ucode_pkg;

   // one horizontal microinstruction, as read from control memory.
   typedef logic [48:0] uinst_t;

   typedef logic [1:0] op_t;     // operation class.
   typedef logic [5:0] src_t;    // M source select.
   typedef logic [4:0] dest_t;   // functional destination select.

   // single-bit sequencing fields.
   localparam int INV_BIT  = 6;  // inverted condition sense.
   localparam int NEXT_BIT = 7;  // N, cancel the following instruction.
   localparam int CALL_BIT = 8;
   localparam int RET_BIT  = 9;
   localparam int POPJ_BIT = 42;

   // multi-bit fields, given by their low bit and width.
   localparam int FUNCT_LSB = 10;
   localparam int FUNCT_W   = 4;
   localparam int JADDR_LSB = 12;
   localparam int JADDR_W   = 14;
   localparam int DEST_LSB  = 19;
   localparam int DEST_W    = 5;
   localparam int SRC_LSB   = 32;
   localparam int SRC_W     = 6;
   localparam int OP_LSB    = 43;
   localparam int OP_W      = 2;

   // operation classes in the op field.
   localparam op_t OP_ALU      = 2'd0;
   localparam op_t OP_JUMP     = 2'd1;
   localparam op_t OP_DISPATCH = 2'd2;
   localparam op_t OP_BYTE     = 2'd3;

   // source and destination codes that touch the SPC stack.
   localparam src_t  SRC_SPC     = 6'h21;   // read the stack top.
   localparam src_t  SRC_SPC_POP = 6'h34;   // read the stack top, then pop.
   localparam dest_t DEST_SPC    = 5'h0a;   // push the M bus onto the stack.

endpackage

// ==== hw/spc_if.sv ====
// SPC stack interface
`timescale 1ns/10ps

interface spc_if;
   import seq_mach_pkg::*;

   logic push;        // stack grows by one entry.
   logic pop;         // stack shrinks by one entry.
   logic wr_strobe;   // pointer and contents may change at this edge.
   logic rd_strobe;   // top latch loads at this edge.
   logic load_m;      // push data comes from the M bus.
   pc_t  ret_addr;    // return address for calls.
   pc_t  m_data;      // M bus data for the stack destination.
   pc_t  top;         // latched top of stack.

   modport ctl (output push, pop, wr_strobe, rd_strobe);
   modport dec (output load_m);
   modport sel (output ret_addr, input top);
   modport stk (input push, pop, wr_strobe, rd_strobe, load_m, ret_addr, m_data,
                output top);

endinterface

// ==== hw/spc_stack.sv ====
// SPC subroutine stack
`timescale 1ns/10ps

module spc_stack
#(
   parameter int SPC_DEPTH_LOG2 = 5
)
(
   input  logic                      clk,
   input  logic                      reset,
   spc_if.stk                        spc,
   output logic [SPC_DEPTH_LOG2-1:0] ptr
);
   import seq_mach_pkg::*;

   localparam int SPC_DEPTH = 1 << SPC_DEPTH_LOG2;

   pc_t                      mem [SPC_DEPTH];
   logic [SPC_DEPTH_LOG2-1:0] ptr_inc;
   pc_t                      push_data;

   // ptr addresses the current top entry and wraps at the stack depth.
   assign ptr_inc   = ptr + 1'b1;
   assign push_data = spc.load_m ? spc.m_data : spc.ret_addr;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ptr <= '0;
         for (int i = 0; i < SPC_DEPTH; i++)
            mem[i] <= '0;
      end
      else if (spc.wr_strobe)
      begin
         if (spc.push && !spc.pop)
         begin
            ptr          <= ptr_inc;
            mem[ptr_inc] <= push_data;
         end
         else if (spc.push)
            mem[ptr] <= push_data;   // fall through, replace the top in place.
         else if (spc.pop)
            ptr <= ptr - 1'b1;
      end
   end

   // read port latch. At the end of write it still sees the old top,
   // so a return through the stack uses the entry before the pop.
   always_ff @(posedge clk)
   begin
      if (reset)
         spc.top <= '0;
      else if (spc.rd_strobe)
         spc.top <= mem[ptr];
   end

endmodule

// ==== verification/seq_ref.svh ====
// Sequencer reference model
`ifndef SEQ_REF_SVH
`define SEQ_REF_SVH

// state of the sequencer between two microinstructions.
typedef struct packed
{
   logic [SPC_DEPTH-1:0][13:0] stk;
   pc_t                        pc;
   logic [SPC_DEPTH_LOG2-1:0]  ptr;
   logic                       nop_d;     // the previous word set N.
   logic                       write_d;   // the previous word was a microcode write.
} seq_state_t;

// one microinstruction. nop is the cancel level during the word, top is the stack
// top that the word reads, and drive tells whether it selects a stack source.
function automatic void seq_step(input uinst_t w, input logic jcond, trap, dn, dp, dr,
                                 input pc_t dpc, m_data, input seq_state_t cur,
                                 output seq_state_t nxt, output logic nop,
                                 output pc_t top, output logic drive);
   op_t  op;
   src_t src;
   logic live, is_jump, is_disp, disp_en, taken, popj_req, blocked;
   logic ret_jump, disp_ret, m_push, push, pop;
   pc_t  ipc;
   op       = w[OP_LSB +: OP_W];
   src      = w[SRC_LSB +: SRC_W];
   nop      = trap | cur.nop_d;
   live     = !nop;
   top      = cur.stk[cur.ptr];
   drive    = (src == SRC_SPC) || (src == SRC_SPC_POP);
   ipc      = cur.pc + 14'd1;
   is_jump  = live && (op == OP_JUMP);
   is_disp  = live && (op == OP_DISPATCH);
   disp_en  = is_disp && !w[FUNCT_LSB + 2];   // function bit 2 holds the dispatch off.
   taken    = is_jump && (jcond != w[INV_BIT]);
   popj_req = (live && w[POPJ_BIT]) || cur.write_d;   // a write forces a popj one word later.
   blocked  = is_disp && !dr;   // a dispatch without return overrides popj.
   ret_jump = taken && w[RET_BIT] && !w[CALL_BIT];
   disp_ret = disp_en && dr && !dp;
   m_push   = live && (op == OP_ALU || op == OP_BYTE) && (w[DEST_LSB +: DEST_W] == DEST_SPC);
   push     = m_push || (taken && w[CALL_BIT]) || (disp_en && dp && !dr);
   pop      = ((popj_req || (live && src == SRC_SPC_POP)) && !blocked) || ret_jump || disp_ret;
   nxt = cur;
   if (push && !pop)
   begin
      nxt.ptr          = cur.ptr + SPC_DEPTH_LOG2'(1);
      nxt.stk[nxt.ptr] = m_push ? m_data : ipc;
   end
   else if (push)
      nxt.stk[cur.ptr] = m_push ? m_data : ipc;   // push and pop replace the top.
   else if (pop)
      nxt.ptr = cur.ptr - SPC_DEPTH_LOG2'(1);
   if ((popj_req && !blocked) || ret_jump || disp_ret)
      nxt.pc = top;
   else if (taken)
      nxt.pc = w[JADDR_LSB +: JADDR_W];
   else if (popj_req || (disp_en && !(dp && dr)))
      nxt.pc = dpc;   // a blocked popj still leaves the dispatch address selected.
   else
      nxt.pc = ipc;
   nxt.nop_d   = trap || cur.write_d || (disp_en && dn) || (taken && w[NEXT_BIT]);
   nxt.write_d = is_jump && w[CALL_BIT] && w[RET_BIT];
endfunction

`endif

// ==== verification/seq_tb.sv ====
// Microcode sequencer testbench
`timescale 1ns/10ps

module seq_tb;
   import seq_ucode_pkg::*;
   import seq_mach_pkg::*;

   localparam int SPC_DEPTH_LOG2 = 5;
   localparam int SPC_DEPTH      = 1 << SPC_DEPTH_LOG2;
   localparam int NUM_DIRECTED   = 27;    // directed words.
   localparam int NUM_RANDOM     = 400;
   localparam int CYCLE_LIMIT    = 4 * (NUM_DIRECTED + NUM_RANDOM) + 200;

   `include "seq_ref.svh"

   logic                      clk = 1'b0;
   logic                      reset;
   uinst_t                    ir;
   logic                      jcond, trap, dn, dp, dr;
   pc_t                       dpc, m_data;
   pc_t                       pc, spc_out;
   seq_phase_t                phase;
   logic                      nop, spc_drive;
   logic [SPC_DEPTH_LOG2-1:0] spc_ptr;

   seq_state_t                st;        // model state before the current word.
   pc_t                       latch;     // top seen by the word just modelled.
   pc_t                       exp_pc, exp_out;
   logic [SPC_DEPTH_LOG2-1:0] exp_ptr;
   logic                      exp_nop, exp_drive;
   logic [1:0]                exp_phase = 2'd0;   // decode, alu, write, fetch in turn.
   logic                      armed = 1'b0;
   string                     test_name = "reset";
   int                        cycles = 0;

   always #2 clk = ~clk;

   seq_top #(.SPC_DEPTH_LOG2(SPC_DEPTH_LOG2)) uut (.clk(clk), .reset(reset), .ir(ir),
      .jcond(jcond), .trap(trap), .dn(dn), .dp(dp), .dr(dr), .dpc(dpc), .m_data(m_data),
      .pc(pc), .phase(phase), .nop(nop), .spc_out(spc_out), .spc_drive(spc_drive),
      .spc_ptr(spc_ptr));

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("MISMATCH %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
         $display("Done: errors found");
         $fatal(1, "stopped at the first wrong value");
      end
   endtask

   // outputs are sampled at the rising edge, half a cycle after the inputs move.
   always @(posedge clk)
   begin
      if (armed)
         check_value("phase", exp_phase, phase);
      if (armed && phase == PH_DECODE)
      begin
         check_value("pc", exp_pc, pc);
         check_value("nop", exp_nop, nop);
         check_value("spc_ptr", exp_ptr, spc_ptr);
         check_value("spc_out", exp_out, spc_out);
         check_value("spc_drive", 1'b0, spc_drive);
      end
      else if (armed)
      begin
         check_value("spc_drive", exp_drive, spc_drive);
         check_value("spc_out", latch, spc_out);   // the word's own top, from alu on.
      end
      if (reset)
         exp_phase <= 2'd0;
      else
         exp_phase <= exp_phase + 2'd1;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
         $display("Done: errors found");
         $fatal(1, "timeout");
      end
   end

   // drives one word in its decode cycle and waits for the next decode.
   task automatic run_instr(input uinst_t w, input logic c, t, w_dn, w_dp, w_dr,
                            input pc_t d, input pc_t m);
      seq_state_t nxt;
      ir      = w;
      jcond   = c;
      trap    = t;
      dn      = w_dn;
      dp      = w_dp;
      dr      = w_dr;
      dpc     = d;
      m_data  = m;
      exp_pc  = st.pc;
      exp_ptr = st.ptr;
      exp_out = latch;
      seq_step(w, c, t, w_dn, w_dp, w_dr, d, m, st, nxt, exp_nop, latch, exp_drive);
      st    = nxt;
      armed = 1'b1;
      do
         @(negedge clk);
      while (phase != PH_DECODE);
   endtask

   function automatic uinst_t alu_word(input src_t src, input dest_t dest, input logic popj);
      uinst_t w;
      w = '0;
      w[SRC_LSB +: SRC_W]   = src;
      w[DEST_LSB +: DEST_W] = dest;
      w[POPJ_BIT]           = popj;
      return w;
   endfunction

   function automatic uinst_t jump_word(input pc_t addr, input logic inv, nxt, call, ret);
      uinst_t w;
      w = '0;
      w[OP_LSB +: OP_W]       = OP_JUMP;
      w[JADDR_LSB +: JADDR_W] = addr;
      w[INV_BIT]              = inv;
      w[NEXT_BIT]             = nxt;
      w[CALL_BIT]             = call;
      w[RET_BIT]              = ret;
      return w;
   endfunction

   function automatic uinst_t disp_word();
      uinst_t w;
      w = '0;
      w[OP_LSB +: OP_W] = OP_DISPATCH;
      return w;
   endfunction

   task automatic run_random();
      uinst_t w;
      w = {17'($urandom()), $urandom()};
      case ($urandom_range(0, 3))
         0: w[SRC_LSB +: SRC_W] = SRC_SPC;
         1: w[SRC_LSB +: SRC_W] = SRC_SPC_POP;
         2: w[DEST_LSB +: DEST_W] = DEST_SPC;
         default: ;
      endcase
      run_instr(w, 1'($urandom()), ($urandom_range(0, 15) == 0), 1'($urandom()),
                1'($urandom()), 1'($urandom()), 14'($urandom()), 14'($urandom()));
   endtask

   initial
   begin
      void'($urandom(52));
      reset  = 1'b1;
      ir     = '0;
      jcond  = 1'b0;
      trap   = 1'b0;
      dn     = 1'b0;
      dp     = 1'b0;
      dr     = 1'b0;
      dpc    = '0;
      m_data = '0;
      st     = '0;
      latch  = '0;
      repeat (10) @(negedge clk);
      reset = 1'b0;
      test_name = "alu run";
      repeat (4) run_instr(alu_word(6'h0, 5'h0, 1'b0), 0, 0, 0, 0, 0, 14'h0, 14'h0);
      test_name = "jump sense";
      run_instr(jump_word(14'h100, 1'b0, 1'b0, 1'b0, 1'b0), 1, 0, 0, 0, 0, 14'h0, 14'h0);
      run_instr(jump_word(14'h120, 1'b0, 1'b0, 1'b0, 1'b0), 0, 0, 0, 0, 0, 14'h0, 14'h0);
      run_instr(jump_word(14'h140, 1'b1, 1'b0, 1'b0, 1'b0), 0, 0, 0, 0, 0, 14'h0, 14'h0);
      run_instr(jump_word(14'h160, 1'b1, 1'b0, 1'b0, 1'b0), 1, 0, 0, 0, 0, 14'h0, 14'h0);
      test_name = "call return";
      run_instr(jump_word(14'h200, 1'b0, 1'b0, 1'b1, 1'b0), 1, 0, 0, 0, 0, 14'h0, 14'h0);
      run_instr(alu_word(6'h0, 5'h0, 1'b0), 0, 0, 0, 0, 0, 14'h0, 14'h0);
      run_instr(jump_word(14'h0, 1'b0, 1'b0, 1'b0, 1'b1), 1, 0, 0, 0, 0, 14'h0, 14'h0);
      run_instr(jump_word(14'h240, 1'b1, 1'b0, 1'b1, 1'b0), 0, 0, 0, 0, 0, 14'h0, 14'h0);
      run_instr(alu_word(6'h0, 5'h0, 1'b1), 0, 0, 0, 0, 0, 14'h0, 14'h0);
      test_name = "cancelled word";
      run_instr(jump_word(14'h300, 1'b0, 1'b1, 1'b0, 1'b0), 1, 0, 0, 0, 0, 14'h0, 14'h0);
      run_instr(jump_word(14'h340, 1'b0, 1'b0, 1'b1, 1'b0), 1, 0, 0, 0, 0, 14'h0, 14'h0);
      run_instr(alu_word(6'h0, 5'h0, 1'b1), 0, 1, 0, 0, 0, 14'h0, 14'h0);
      run_instr(alu_word(6'h0, 5'h0, 1'b1), 0, 0, 0, 0, 0, 14'h0, 14'h0);
      test_name = "dispatch";
      run_instr(disp_word(), 0, 0, 0, 0, 0, 14'h400, 14'h0);
      run_instr(disp_word(), 0, 0, 0, 1, 0, 14'h420, 14'h0);
      run_instr(disp_word(), 0, 0, 0, 0, 1, 14'h440, 14'h0);
      run_instr(disp_word(), 0, 0, 0, 1, 1, 14'h460, 14'h0);
      run_instr(disp_word(), 0, 0, 1, 0, 0, 14'h480, 14'h0);
      run_instr(disp_word(), 0, 0, 0, 1, 0, 14'h4a0, 14'h0);
      test_name = "stack m bus";
      run_instr(alu_word(6'h0, DEST_SPC, 1'b0), 0, 0, 0, 0, 0, 14'h0, 14'h2aa);
      run_instr(alu_word(SRC_SPC, 5'h0, 1'b0), 0, 0, 0, 0, 0, 14'h0, 14'h0);
      run_instr(alu_word(SRC_SPC_POP, 5'h0, 1'b0), 0, 0, 0, 0, 0, 14'h0, 14'h0);
      run_instr(alu_word(6'h0, 5'h0, 1'b0), 0, 0, 0, 0, 0, 14'h0, 14'h0);
      test_name = "random mix";
      repeat (NUM_RANDOM) run_random();
      armed = 1'b0;
      test_name = "final state";
      check_value("pc", st.pc, pc);
      check_value("spc_ptr", st.ptr, spc_ptr);
      check_value("spc_out", latch, spc_out);
      $display("Done: no errors");
      $finish;
   end

endmodule
